// File: source/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// data path width
`define CSR_XLEN 32

// identity registers, read only
`define CSR_MVENDORID 32'h0000_0000
`define CSR_MARCHID   32'h0000_0001
`define CSR_MIMPID    32'h0000_0100
`define CSR_MHARTID   32'h0000_0000

`define CSR_MSTATUS_VALUE 32'h0000_1800 // mpp = machine
`define CSR_MISA_VALUE    32'h4000_0100 // mxl = 32, base i

// direct mode trap vector after reset
`define CSR_MTVEC_RESET 32'h0000_1000

// mcause for illegal instruction
`define CSR_CAUSE_ILLEGAL 32'd2

`endif

// File: source/csr_pkg.sv
`default_nettype none
`include "csr_settings.svh"

package csr_pkg;

    typedef enum logic [11:0] {
        ADDR_MSTATUS   = 12'h300,
        ADDR_MISA      = 12'h301,
        ADDR_MTVEC     = 12'h305,
        ADDR_MEPC      = 12'h341,
        ADDR_MCAUSE    = 12'h342,
        ADDR_MCYCLE    = 12'hB00,
        ADDR_MINSTRET  = 12'hB02,
        ADDR_MCYCLEH   = 12'hB80,
        ADDR_MINSTRETH = 12'hB82,
        ADDR_MVENDORID = 12'hF11,
        ADDR_MARCHID   = 12'hF12,
        ADDR_MIMPID    = 12'hF13,
        ADDR_MHARTID   = 12'hF14
    } csr_addr_e;

    // low bits of funct3, code 0 is unused
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    // what the trap unit redirects next cycle
    typedef enum logic [1:0] {
        REDIR_NONE,
        REDIR_TRAP,
        REDIR_MRET
    } csr_redir_e;

    typedef struct packed {
        csr_op_e              op;
        logic [11:0]          addr;   // raw, may be unimplemented
        logic [`CSR_XLEN-1:0] src;
        logic [`CSR_XLEN-1:0] pc;
    } csr_req_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0] data;   // value before the write
        logic                 illegal;
    } csr_rsp_t;

    typedef struct packed {
        logic                 en;
        logic [11:0]          addr;
        logic [`CSR_XLEN-1:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0] cause;
        logic [`CSR_XLEN-1:0] epc;
    } csr_trap_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0] pc;
    } csr_redirect_t;

endpackage

`default_nettype wire

// File: source/csr_op_unit.sv
`default_nettype none
`timescale 1ns/1ns
`include "csr_settings.svh"

module csr_op_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    input  csr_pkg::csr_req_t    req,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output csr_pkg::csr_rsp_t    rsp,
    input  logic                 rsp_ready,
    output csr_pkg::csr_addr_e   rd_addr,
    input  logic [`CSR_XLEN-1:0] rd_data,
    output csr_pkg::csr_wr_t     wr,
    output logic                 illegal_valid,
    output logic [`CSR_XLEN-1:0] illegal_pc
);

    logic                 rsp_pending;
    logic                 accept;
    logic                 implemented;
    logic                 read_only;
    logic                 op_known;
    logic                 writes;
    logic                 illegal;
    logic [`CSR_XLEN-1:0] new_value;

    assign req_ready = !rsp_pending; // one request in flight
    assign rsp_valid = rsp_pending;
    assign accept    = req_valid && req_ready;
    assign rd_addr   = csr_pkg::csr_addr_e'(req.addr);

    always_comb begin
        case (req.addr)
            csr_pkg::ADDR_MVENDORID, csr_pkg::ADDR_MARCHID,
            csr_pkg::ADDR_MIMPID, csr_pkg::ADDR_MHARTID,
            csr_pkg::ADDR_MSTATUS, csr_pkg::ADDR_MISA,
            csr_pkg::ADDR_MTVEC, csr_pkg::ADDR_MEPC, csr_pkg::ADDR_MCAUSE,
            csr_pkg::ADDR_MCYCLE, csr_pkg::ADDR_MINSTRET,
            csr_pkg::ADDR_MCYCLEH, csr_pkg::ADDR_MINSTRETH: implemented = 1'b1;
            default: implemented = 1'b0;
        endcase
    end

    // top two address bits 11 mark a read-only csr
    assign read_only = (req.addr[11:10] == 2'b11);

    always_comb begin
        op_known  = 1'b1;
        writes    = 1'b0;
        new_value = rd_data;
        case (req.op)
            csr_pkg::CSR_RW: begin
                writes    = 1'b1;
                new_value = req.src;
            end
            csr_pkg::CSR_RS: begin
                writes    = |req.src; // zero source is a pure read
                new_value = rd_data | req.src;
            end
            csr_pkg::CSR_RC: begin
                writes    = |req.src;
                new_value = rd_data & ~req.src;
            end
            default: op_known = 1'b0;
        endcase
    end

    assign illegal = !implemented || !op_known || (read_only && writes);

    assign wr            = '{en: accept && !illegal && writes, addr: req.addr, data: new_value};
    assign illegal_valid = accept && illegal;
    assign illegal_pc    = req.pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_pending <= 1'b0;
        end else if (accept) begin
            rsp_pending <= 1'b1;
        end else if (rsp_valid && rsp_ready) begin
            rsp_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp <= '{data: illegal ? '0 : rd_data, illegal: illegal};
        end
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("response changed while stalled");

    // writes only reach writable csrs with a known operation
    a_illegal_no_write: assert property (@(posedge clk) disable iff (reset)
        wr.en |-> (req.op inside {csr_pkg::CSR_RW, csr_pkg::CSR_RS, csr_pkg::CSR_RC})
                  && (req.addr inside {csr_pkg::ADDR_MSTATUS, csr_pkg::ADDR_MISA,
                                       csr_pkg::ADDR_MTVEC, csr_pkg::ADDR_MEPC,
                                       csr_pkg::ADDR_MCAUSE, csr_pkg::ADDR_MCYCLE,
                                       csr_pkg::ADDR_MINSTRET, csr_pkg::ADDR_MCYCLEH,
                                       csr_pkg::ADDR_MINSTRETH}))
        else $error("write issued for an illegal csr access");

endmodule

`default_nettype wire

// File: source/csr_file.sv
`default_nettype none
`timescale 1ns/1ns
`include "csr_settings.svh"

module csr_file (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_addr_e   rd_addr,
    output logic [`CSR_XLEN-1:0] rd_data,
    input  csr_pkg::csr_wr_t     wr,
    input  logic                 trap_wr_en,
    input  csr_pkg::csr_trap_t   trap_wr,
    input  logic                 retire,
    output logic [`CSR_XLEN-1:0] mtvec,
    output logic [`CSR_XLEN-1:0] mepc
);

    logic [`CSR_XLEN-1:0] mcause;
    logic [63:0]          mcycle;
    logic [63:0]          minstret;

    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mcycle;
    logic wr_mcycleh;
    logic wr_minstret;
    logic wr_minstreth;

    // a written half holds the new data and skips the increment
    function automatic logic [63:0] counter_next(
        input logic [63:0]          cur,
        input logic                 inc,
        input logic                 wr_lo,
        input logic                 wr_hi,
        input logic [`CSR_XLEN-1:0] data
    );
        logic [63:0] bumped;
        bumped = cur + {63'd0, inc};
        if (wr_lo) begin
            counter_next = {cur[63:32], data};
        end else if (wr_hi) begin
            counter_next = {data, bumped[31:0]};
        end else begin
            counter_next = bumped;
        end
    endfunction

    assign wr_mtvec     = wr.en && (wr.addr == csr_pkg::ADDR_MTVEC);
    assign wr_mepc      = wr.en && (wr.addr == csr_pkg::ADDR_MEPC);
    assign wr_mcause    = wr.en && (wr.addr == csr_pkg::ADDR_MCAUSE);
    assign wr_mcycle    = wr.en && (wr.addr == csr_pkg::ADDR_MCYCLE);
    assign wr_mcycleh   = wr.en && (wr.addr == csr_pkg::ADDR_MCYCLEH);
    assign wr_minstret  = wr.en && (wr.addr == csr_pkg::ADDR_MINSTRET);
    assign wr_minstreth = wr.en && (wr.addr == csr_pkg::ADDR_MINSTRETH);

    always_comb begin
        case (rd_addr)
            csr_pkg::ADDR_MVENDORID: rd_data = `CSR_MVENDORID;
            csr_pkg::ADDR_MARCHID:   rd_data = `CSR_MARCHID;
            csr_pkg::ADDR_MIMPID:    rd_data = `CSR_MIMPID;
            csr_pkg::ADDR_MHARTID:   rd_data = `CSR_MHARTID;
            csr_pkg::ADDR_MSTATUS:   rd_data = `CSR_MSTATUS_VALUE;
            csr_pkg::ADDR_MISA:      rd_data = `CSR_MISA_VALUE;
            csr_pkg::ADDR_MTVEC:     rd_data = mtvec;
            csr_pkg::ADDR_MEPC:      rd_data = mepc;
            csr_pkg::ADDR_MCAUSE:    rd_data = mcause;
            csr_pkg::ADDR_MCYCLE:    rd_data = mcycle[31:0];
            csr_pkg::ADDR_MCYCLEH:   rd_data = mcycle[63:32];
            csr_pkg::ADDR_MINSTRET:  rd_data = minstret[31:0];
            csr_pkg::ADDR_MINSTRETH: rd_data = minstret[63:32];
            default:                 rd_data = '0; // unimplemented reads zero
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mtvec    <= `CSR_MTVEC_RESET;
            mepc     <= '0;
            mcause   <= '0;
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            if (wr_mtvec) begin
                mtvec <= {wr.data[`CSR_XLEN-1:2], 2'b00}; // direct mode only
            end
            if (trap_wr_en) begin // trap beats instruction write
                mepc   <= {trap_wr.epc[`CSR_XLEN-1:2], 2'b00};
                mcause <= trap_wr.cause;
            end else begin
                if (wr_mepc) begin
                    mepc <= {wr.data[`CSR_XLEN-1:2], 2'b00};
                end
                if (wr_mcause) begin
                    mcause <= wr.data;
                end
            end
            mcycle   <= counter_next(mcycle, 1'b1, wr_mcycle, wr_mcycleh, wr.data);
            minstret <= counter_next(minstret, retire, wr_minstret, wr_minstreth, wr.data);
        end
    end

endmodule

`default_nettype wire

// File: source/csr_trap_unit.sv
`default_nettype none
`timescale 1ns/1ns
`include "csr_settings.svh"

module csr_trap_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   trap_valid,
    input  csr_pkg::csr_trap_t     trap_info,
    input  logic                   mret,
    input  logic                   illegal_valid,
    input  logic [`CSR_XLEN-1:0]   illegal_pc,
    input  logic [`CSR_XLEN-1:0]   mtvec,
    input  logic [`CSR_XLEN-1:0]   mepc,
    output logic                   trap_wr_en,
    output csr_pkg::csr_trap_t     trap_wr,
    output logic                   redirect_valid,
    output csr_pkg::csr_redirect_t redirect
);

    csr_pkg::csr_redir_e state;

    assign trap_wr_en = trap_valid || illegal_valid;

    always_comb begin
        if (illegal_valid) begin // own exception wins
            trap_wr.cause = `CSR_CAUSE_ILLEGAL;
            trap_wr.epc   = illegal_pc;
        end else begin
            trap_wr = trap_info;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= csr_pkg::REDIR_NONE;
        end else if (trap_wr_en) begin
            state <= csr_pkg::REDIR_TRAP;
        end else if (mret) begin
            state <= csr_pkg::REDIR_MRET;
        end else begin
            state <= csr_pkg::REDIR_NONE;
        end
    end

    // file values are already updated by the trap write
    assign redirect_valid = (state != csr_pkg::REDIR_NONE);
    assign redirect.pc    = (state == csr_pkg::REDIR_MRET) ? mepc : mtvec;

    a_trap_mret: assert property (@(posedge clk) disable iff (reset)
        !(trap_valid && mret))
        else $error("trap and mret in the same cycle");

    a_trap_illegal: assert property (@(posedge clk) disable iff (reset)
        !(trap_valid && illegal_valid))
        else $error("external trap dropped by an illegal csr access");

endmodule

`default_nettype wire

// File: source/csr_unit.sv
`default_nettype none
`timescale 1ns/1ns
`include "csr_settings.svh"

module csr_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    input  csr_pkg::csr_req_t      req,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output csr_pkg::csr_rsp_t      rsp,
    input  logic                   rsp_ready,
    input  logic                   trap_valid,
    input  csr_pkg::csr_trap_t     trap_info,
    input  logic                   mret,
    input  logic                   retire,
    output logic                   redirect_valid,
    output csr_pkg::csr_redirect_t redirect
);

    csr_pkg::csr_addr_e   rd_addr;
    logic [`CSR_XLEN-1:0] rd_data;
    csr_pkg::csr_wr_t     wr;
    logic                 illegal_valid;
    logic [`CSR_XLEN-1:0] illegal_pc;
    logic                 trap_wr_en;
    csr_pkg::csr_trap_t   trap_wr;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mepc;

    csr_op_unit u_op (
        .clk, .reset,
        .req_valid, .req, .req_ready,
        .rsp_valid, .rsp, .rsp_ready,
        .rd_addr, .rd_data,
        .wr,
        .illegal_valid, .illegal_pc
    );

    csr_file u_file (
        .clk, .reset,
        .rd_addr, .rd_data,
        .wr,
        .trap_wr_en, .trap_wr,
        .retire,
        .mtvec, .mepc
    );

    csr_trap_unit u_trap (
        .clk, .reset,
        .trap_valid, .trap_info, .mret,
        .illegal_valid, .illegal_pc,
        .mtvec, .mepc,
        .trap_wr_en, .trap_wr,
        .redirect_valid, .redirect
    );

endmodule

`default_nettype wire

// File: tb/csr_unit_tb.sv
`default_nettype none
`timescale 1ns/1ns
`include "csr_settings.svh"

module csr_unit_tb;

    localparam int NUM_REQ     = 300;
    localparam int CYCLE_LIMIT = 10 * NUM_REQ + 200;

    logic                   clk;
    logic                   reset;
    logic                   req_valid;
    csr_pkg::csr_req_t      req;
    logic                   req_ready;
    logic                   rsp_valid;
    csr_pkg::csr_rsp_t      rsp;
    logic                   rsp_ready;
    logic                   trap_valid;
    csr_pkg::csr_trap_t     trap_info;
    logic                   mret;
    logic                   retire;
    logic                   redirect_valid;
    csr_pkg::csr_redirect_t redirect;

    integer      seed = 32'h1d7d1b4a;
    int          cycles = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;
    logic        hang = 1'b0; // set when a handshake stalls
    logic [31:0] m_mtvec = `CSR_MTVEC_RESET;
    logic [31:0] m_mepc = '0;
    logic [31:0] m_mcause = '0;
    logic [31:0] m_mcycleh = '0;
    logic [63:0] m_minstret = '0; // exact, retire only pulses while idle
    logic [31:0] last_mcycle = '0; // last mcycle read or lower bound after a write

    csr_pkg::csr_addr_e addr_list [13] = '{
        csr_pkg::ADDR_MVENDORID, csr_pkg::ADDR_MARCHID, csr_pkg::ADDR_MIMPID,
        csr_pkg::ADDR_MHARTID, csr_pkg::ADDR_MSTATUS, csr_pkg::ADDR_MISA,
        csr_pkg::ADDR_MTVEC, csr_pkg::ADDR_MEPC, csr_pkg::ADDR_MCAUSE,
        csr_pkg::ADDR_MCYCLE, csr_pkg::ADDR_MCYCLEH,
        csr_pkg::ADDR_MINSTRET, csr_pkg::ADDR_MINSTRETH};
    csr_pkg::csr_op_e op_list [3] = '{csr_pkg::CSR_RW, csr_pkg::CSR_RS, csr_pkg::CSR_RC};

    csr_unit dut0 (
        .clk, .reset,
        .req_valid, .req, .req_ready,
        .rsp_valid, .rsp, .rsp_ready,
        .trap_valid, .trap_info, .mret,
        .retire,
        .redirect_valid, .redirect
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #2; // outputs settled, inputs change here
    endtask

    function automatic logic is_implemented(input logic [11:0] addr);
        is_implemented = 1'b0;
        foreach (addr_list[i]) begin
            if (addr == addr_list[i]) is_implemented = 1'b1;
        end
    endfunction

    function automatic logic is_read_only(input logic [11:0] addr);
        is_read_only = addr inside {csr_pkg::ADDR_MVENDORID, csr_pkg::ADDR_MARCHID,
                                    csr_pkg::ADDR_MIMPID, csr_pkg::ADDR_MHARTID};
    endfunction

    // mcycle reads zero here so a write yields its lower bound
    function automatic logic [31:0] model_value(input logic [11:0] addr);
        case (addr)
            csr_pkg::ADDR_MVENDORID: model_value = `CSR_MVENDORID;
            csr_pkg::ADDR_MARCHID:   model_value = `CSR_MARCHID;
            csr_pkg::ADDR_MIMPID:    model_value = `CSR_MIMPID;
            csr_pkg::ADDR_MHARTID:   model_value = `CSR_MHARTID;
            csr_pkg::ADDR_MSTATUS:   model_value = `CSR_MSTATUS_VALUE;
            csr_pkg::ADDR_MISA:      model_value = `CSR_MISA_VALUE;
            csr_pkg::ADDR_MTVEC:     model_value = m_mtvec;
            csr_pkg::ADDR_MEPC:      model_value = m_mepc;
            csr_pkg::ADDR_MCAUSE:    model_value = m_mcause;
            csr_pkg::ADDR_MCYCLEH:   model_value = m_mcycleh;
            csr_pkg::ADDR_MINSTRET:  model_value = m_minstret[31:0];
            csr_pkg::ADDR_MINSTRETH: model_value = m_minstret[63:32];
            default:                 model_value = '0;
        endcase
    endfunction

    task automatic model_write(input logic [11:0] addr, input logic [31:0] value);
        case (addr)
            csr_pkg::ADDR_MTVEC:     m_mtvec = {value[31:2], 2'b00};
            csr_pkg::ADDR_MEPC:      m_mepc = {value[31:2], 2'b00};
            csr_pkg::ADDR_MCAUSE:    m_mcause = value;
            csr_pkg::ADDR_MCYCLEH:   m_mcycleh = value;
            csr_pkg::ADDR_MINSTRET:  m_minstret[31:0] = value;
            csr_pkg::ADDR_MINSTRETH: m_minstret[63:32] = value;
            default: ;
        endcase
    endtask

    task automatic check_rsp(input csr_pkg::csr_rsp_t got, input csr_pkg::csr_rsp_t exp,
                             input logic [11:0] addr);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0t: csr %h returned data %h illegal %b, expected %h %b",
                     $time, addr, got.data, got.illegal, exp.data, exp.illegal);
        end
    endtask

    task automatic check_increasing(input csr_pkg::csr_rsp_t got, input logic [31:0] floor);
        if ($isunknown(got) || got.illegal || got.data <= floor) begin
            value_errors++;
            $display("Error at %0t: mcycle read %h illegal %b, expected above %h",
                     $time, got.data, got.illegal, floor);
        end
    endtask

    task automatic check_redirect(input csr_pkg::csr_redirect_t exp);
        if (redirect_valid !== 1'b1) begin
            protocol_errors++;
            $display("missing redirect: redirect_valid low one cycle after a trap at %0t", $time);
        end else if (redirect !== exp) begin
            value_errors++;
            $display("Error at %0t: redirect to %h, expected %h", $time, redirect.pc, exp.pc);
        end
    endtask

    task automatic do_request(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                              input logic [31:0] src, input logic [31:0] pc);
        csr_pkg::csr_rsp_t      exp;
        csr_pkg::csr_redirect_t exp_redir;
        logic                   writes;
        logic                   done;
        logic [31:0]            old;
        logic [31:0]            new_value;
        int                     waited;
        if (hang) return;
        writes      = (op == csr_pkg::CSR_RW) || (src != '0);
        old         = model_value(addr);
        exp.illegal = !is_implemented(addr) || (is_read_only(addr) && writes);
        exp.data    = exp.illegal ? '0 : old;
        case (op)
            csr_pkg::CSR_RW: new_value = src;
            csr_pkg::CSR_RS: new_value = old | src;
            default:         new_value = old & ~src;
        endcase
        req       = '{op: op, addr: addr, src: src, pc: pc};
        req_valid = 1'b1;
        waited    = 0;
        while (!hang && req_ready !== 1'b1) begin
            step();
            waited++;
            if (waited > 20) begin
                protocol_errors++;
                hang = 1'b1;
                $display("stalled handshake: request not accepted within 20 cycles");
            end
        end
        if (hang) return;
        step(); // acceptance edge
        req_valid = 1'b0;
        exp_redir.pc = m_mtvec;
        if (exp.illegal) begin
            m_mepc   = {pc[31:2], 2'b00};
            m_mcause = `CSR_CAUSE_ILLEGAL;
            check_redirect(exp_redir);
        end else begin
            if (writes) model_write(addr, new_value);
            if (redirect_valid !== 1'b0) begin
                protocol_errors++;
                $display("unexpected redirect after legal access to csr %h", addr);
            end
        end
        if (rsp_valid !== 1'b1) begin
            protocol_errors++;
            hang = 1'b1;
            $display("stalled handshake: no response one cycle after acceptance");
            return;
        end
        done = 1'b0;
        while (!done && !hang) begin
            if (addr == csr_pkg::ADDR_MCYCLE) check_increasing(rsp, last_mcycle);
            else check_rsp(rsp, exp, addr);
            rsp_ready = ($random(seed) & 3) != 0; // back-pressure one cycle in four
            done = rsp_ready;
            step();
            if (!done && rsp_valid !== 1'b1) begin
                protocol_errors++;
                hang = 1'b1;
                $display("response withdrawn before rsp_ready was seen");
            end
        end
        rsp_ready = 1'b0;
        if (!hang && rsp_valid !== 1'b0) begin
            protocol_errors++;
            hang = 1'b1;
            $display("second response for a single request");
        end
        if (addr == csr_pkg::ADDR_MCYCLE) last_mcycle = writes ? new_value : rsp.data;
    endtask

    task automatic idle_cycle();
        csr_pkg::csr_redirect_t exp_redir;
        int                     pick;
        pick = $unsigned($random(seed)) % 16;
        if (pick < 4) begin
            retire = 1'b1;
            m_minstret++;
            step();
            retire = 1'b0;
        end else if (pick == 4) begin
            trap_info.cause = $random(seed);
            trap_info.epc   = $random(seed);
            trap_valid      = 1'b1;
            m_mepc          = {trap_info.epc[31:2], 2'b00};
            m_mcause        = trap_info.cause;
            exp_redir.pc    = m_mtvec;
            step();
            trap_valid = 1'b0;
            check_redirect(exp_redir);
        end else if (pick == 5) begin
            mret         = 1'b1;
            exp_redir.pc = m_mepc;
            step();
            mret = 1'b0;
            check_redirect(exp_redir);
        end else begin
            step();
        end
    endtask

    initial begin
        int          pick;
        logic [11:0] addr;
        logic [31:0] src;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b0;
        trap_valid = 1'b0;
        trap_info  = '0;
        mret       = 1'b0;
        retire     = 1'b0;
        repeat (2) @(posedge clk);
        #2 reset = 1'b0;
        step();
        for (int i = 0; i < 7; i++) begin // identity, mstatus, misa, mtvec
            do_request(csr_pkg::CSR_RS, addr_list[i], '0, '0);
        end
        do_request(csr_pkg::CSR_RS, csr_pkg::ADDR_MTVEC, '0, '0);
        do_request(csr_pkg::CSR_RW, csr_pkg::ADDR_MHARTID, 32'h5, 32'h2000_0104);
        do_request(csr_pkg::CSR_RS, csr_pkg::ADDR_MCAUSE, '0, '0);
        do_request(csr_pkg::CSR_RS, csr_pkg::ADDR_MEPC, '0, '0);
        do_request(csr_pkg::CSR_RC, 12'h7c0, '0, 32'h0000_0040); // unimplemented
        for (int i = 0; i < NUM_REQ && !hang; i++) begin
            pick = $unsigned($random(seed)) % 16;
            addr = (pick < 13) ? addr_list[pick] : $random(seed);
            src  = $random(seed);
            if (($random(seed) & 3) == 0) src = '0;
            if (addr == csr_pkg::ADDR_MCYCLE) src[31:20] = '0; // keep mcycle far from wrap
            do_request(op_list[$unsigned($random(seed)) % 3], addr, src, $random(seed));
            repeat ($unsigned($random(seed)) % 3) idle_cycle();
        end
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/csr_pkg.sv
source/csr_op_unit.sv
source/csr_file.sv
source/csr_trap_unit.sv
source/csr_unit.sv
tb/csr_unit_tb.sv
